// File: rp_config.svh
// Global sizing for the analog signal path
// Channel count, sample and bus widths, table and phase sizes, ID word

`ifndef RP_CONFIG_SVH
`define RP_CONFIG_SVH

// Generator and ADC channels
`define RP_MNG 2

// Converter sample width
`define RP_SDW 14

// System bus
`define RP_SAW 20               // Byte address width
`define RP_ID  32'h5250_4153    // Read back at housekeeping 0x0

// Waveform table and phase accumulator
`define RP_TAW 8                // Table index bits
`define RP_TDP (1 << `RP_TAW)   // Table depth, 256 entries
`define RP_PHW 16               // Top RP_TAW bits index the table

`endif

// File: hw/rp_bus_pkg.sv
// System bus request and response structs
// Region map on the top address nibble

`default_nettype none
`include "rp_config.svh"

package rp_bus_pkg;

  // Request from processor side, strobes last one cycle
  typedef struct packed {
    logic [`RP_SAW-1:0] addr;   // Byte address
    logic [31:0]        wdata;  // Write data
    logic               wen;    // Write strobe
    logic               ren;    // Read strobe
  } sys_req_t;

  // Response, one cycle after the strobe
  typedef struct packed {
    logic [31:0] rdata;  // Valid with ack only
    logic        ack;
    logic        err;    // Unmapped region
  } sys_rsp_t;

  // Top address nibble, all other codes unmapped
  typedef enum logic [3:0] {
    REG_HK  = 4'h0,  // Housekeeping
    REG_CH0 = 4'h1,  // Generator channel 0
    REG_CH1 = 4'h2   // Generator channel 1
  } region_e;

endpackage : rp_bus_pkg

`default_nettype wire

// File: hw/rp_sig_pkg.sv
// Sample and converter code types
// Generator channel settings, register map and channel states

`default_nettype none
`include "rp_config.svh"

package rp_sig_pkg;

  // Two's complement sample inside the fabric
  typedef logic signed [`RP_SDW-1:0] sample_t;

  // Negative slope offset binary code at the converters
  typedef logic [`RP_SDW-1:0] raw_t;

  // Settings of one generator channel
  typedef struct packed {
    logic               enable;    // Play table
    logic [`RP_PHW-1:0] step;      // Phase increment per cycle
    logic               tbl_we;    // One cycle table write strobe
    logic [`RP_TAW-1:0] tbl_addr;  // Entry index
    sample_t            tbl_data;  // Entry value
  } asg_cfg_t;

  // Byte offset inside a channel region
  typedef enum logic [15:0] {
    CR_CTRL  = 16'h0000,  // Bit 0 enable
    CR_STEP  = 16'h0004,  // Phase step
    CR_TABLE = 16'h8000   // Base of the write-only table
  } chan_reg_e;

  // Generator channel state
  typedef enum logic {
    CH_IDLE,
    CH_RUN
  } chan_state_e;

endpackage : rp_sig_pkg

`default_nettype wire

// File: hw/rp_bus_decoder.sv
// System bus decoder, housekeeping and channel registers
// Registered read mux with ack and err one cycle after the strobe

`timescale 1ns/10ps
`default_nettype none
`include "rp_config.svh"

module rp_bus_decoder
  import rp_bus_pkg::*, rp_sig_pkg::*;
(
  input  logic                     adc_clk,
  input  logic                     rst_n_i,         // Sync reset, active low
  input  sys_req_t                 sys_req_i,       // Bus request
  output sys_rsp_t                 sys_rsp_o,       // Bus response
  input  sample_t  [`RP_MNG-1:0]   adc_smp_i,       // Converted ADC samples
  output asg_cfg_t [`RP_MNG-1:0]   cfg_o,           // Per channel settings
  output logic                     digital_loop_o   // ADC replaced by generator
);

////////////////////////////////////////////////////////////
// Address decode
////////////////////////////////////////////////////////////

region_e                       region;
logic [15:0]                   offset;    // Offset inside region
chan_reg_e                     creg;
logic [`RP_MNG-1:0]            ch_hit;    // One hot channel region
logic                          unmapped;
logic [31:0]                   rd_data;

// Control registers
logic [`RP_MNG-1:0]              en_q;
logic [`RP_MNG-1:0][`RP_PHW-1:0] step_q;
logic [`RP_MNG-1:0]              tbl_we_q;
logic                            loop_q;
logic                            ack_q;
logic                            err_q;

// Payload registers
logic [`RP_TAW-1:0]            tbl_addr_q;
sample_t                       tbl_data_q;
logic [31:0]                   rdata_q;

assign region = region_e'(sys_req_i.addr[`RP_SAW-1 -: 4]);
assign offset = sys_req_i.addr[15:0];
assign creg   = offset[15] ? CR_TABLE : chan_reg_e'(offset);  // Whole upper half is table

always_comb
begin
  for (int i = 0; i < `RP_MNG; i++)
  begin
    ch_hit[i] = (sys_req_i.addr[`RP_SAW-1 -: 4] == 4'(int'(REG_CH0) + i));
  end
end

////////////////////////////////////////////////////////////
// Read mux
////////////////////////////////////////////////////////////

always_comb
begin
  rd_data  = '0;
  unmapped = 1'b0;
  case (region)
    REG_HK:
    begin
      if (offset == 16'h0)
        rd_data = `RP_ID;
      else if (offset == 16'h4)
        rd_data = 32'(loop_q);
      for (int i = 0; i < `RP_MNG; i++)
      begin
        if (offset == 16'(8 + 4 * i))  // ADC read-back from 0x8 upwards
          rd_data = {{(32-`RP_SDW){adc_smp_i[i][`RP_SDW-1]}}, adc_smp_i[i]};
      end
    end
    REG_CH0, REG_CH1:
    begin
      for (int i = 0; i < `RP_MNG; i++)
      begin
        if (ch_hit[i])
        begin
          case (creg)
            CR_CTRL: rd_data = 32'(en_q[i]);
            CR_STEP: rd_data = 32'(step_q[i]);
            default: rd_data = '0;  // Table is write-only
          endcase
        end
      end
    end
    default: unmapped = 1'b1;
  endcase
end

////////////////////////////////////////////////////////////
// Register writes and response
////////////////////////////////////////////////////////////

always_ff @(posedge adc_clk)
begin
  if (!rst_n_i)
  begin
    en_q     <= '0;
    step_q   <= '0;
    tbl_we_q <= '0;
    loop_q   <= 1'b0;
    ack_q    <= 1'b0;
    err_q    <= 1'b0;
  end
  else
  begin
    tbl_we_q <= '0;                                          // Strobe for one cycle
    ack_q    <= sys_req_i.wen | sys_req_i.ren;
    err_q    <= (sys_req_i.wen | sys_req_i.ren) & unmapped;
    if (sys_req_i.wen)
    begin
      if (region == REG_HK && offset == 16'h4)
        loop_q <= sys_req_i.wdata[0];
      for (int i = 0; i < `RP_MNG; i++)
      begin
        if (ch_hit[i])
        begin
          case (creg)
            CR_CTRL:  en_q[i]     <= sys_req_i.wdata[0];
            CR_STEP:  step_q[i]   <= sys_req_i.wdata[`RP_PHW-1:0];
            CR_TABLE: tbl_we_q[i] <= 1'b1;
            default:  ;
          endcase
        end
      end
    end
  end
end

// Table entry and read data
always_ff @(posedge adc_clk)
begin
  if (sys_req_i.wen && creg == CR_TABLE)
  begin
    tbl_addr_q <= offset[2 +: `RP_TAW];                     // Word index
    tbl_data_q <= sample_t'(sys_req_i.wdata[`RP_SDW-1:0]);
  end
  if (sys_req_i.ren)
    rdata_q <= rd_data;
end

always_comb
begin
  for (int i = 0; i < `RP_MNG; i++)
  begin
    cfg_o[i].enable   = en_q[i];
    cfg_o[i].step     = step_q[i];
    cfg_o[i].tbl_we   = tbl_we_q[i];
    cfg_o[i].tbl_addr = tbl_addr_q;  // Shared, strobe picks the channel
    cfg_o[i].tbl_data = tbl_data_q;
  end
end

assign digital_loop_o = loop_q;
assign sys_rsp_o      = '{rdata: rdata_q, ack: ack_q, err: err_q};

endmodule : rp_bus_decoder

`default_nettype wire

// File: hw/rp_asg_channel.sv
// Arbitrary signal generator channel
// Table RAM, phase accumulator and wrap trigger

`timescale 1ns/10ps
`default_nettype none
`include "rp_config.svh"

module rp_asg_channel
  import rp_sig_pkg::*;
(
  input  logic     adc_clk,
  input  logic     rst_n_i,  // Sync reset, active low
  input  asg_cfg_t cfg_i,    // Settings from decoder
  output sample_t  smp_o,    // Table sample
  output logic     trig_o    // Pulse on phase wrap
);

sample_t            tbl_mem [`RP_TDP];  // Waveform table
chan_state_e        state_q;
logic [`RP_PHW-1:0] phase_q;
logic [`RP_PHW:0]   phase_sum;          // Extra bit is the wrap carry
logic [`RP_TAW-1:0] tbl_idx;
sample_t            smp_q;
logic               trig_q;

assign phase_sum = {1'b0, phase_q} + {1'b0, cfg_i.step};
assign tbl_idx   = phase_q[`RP_PHW-1 -: `RP_TAW];  // Integer part of phase

// Table write port
always_ff @(posedge adc_clk)
begin
  if (cfg_i.tbl_we)
    tbl_mem[cfg_i.tbl_addr] <= cfg_i.tbl_data;
end

////////////////////////////////////////////////////////////
// Playback FSM
////////////////////////////////////////////////////////////

always_ff @(posedge adc_clk)
begin
  if (!rst_n_i)
  begin
    state_q <= CH_IDLE;
    phase_q <= '0;
    smp_q   <= '0;
    trig_q  <= 1'b0;
  end
  else
  begin
    trig_q <= 1'b0;
    case (state_q)
      CH_IDLE:
      begin
        phase_q <= '0;
        smp_q   <= '0;
        if (cfg_i.enable)
          state_q <= CH_RUN;  // Phase 0 is read on the next edge
      end
      CH_RUN:
      begin
        if (!cfg_i.enable)
        begin
          state_q <= CH_IDLE;
          phase_q <= '0;
          smp_q   <= '0;
        end
        else
        begin
          phase_q <= phase_sum[`RP_PHW-1:0];
          smp_q   <= tbl_mem[tbl_idx];        // Registered read, one cycle late
          trig_q  <= phase_sum[`RP_PHW];      // Wrapped past full scale
        end
      end
      default: state_q <= CH_IDLE;
    endcase
  end
end

assign smp_o  = smp_q;
assign trig_o = trig_q;

endmodule : rp_asg_channel

`default_nettype wire

// File: hw/rp_analog_io.sv
// ADC input registers and conversion to two's complement
// Digital loop mux and registered DAC codes

`timescale 1ns/10ps
`default_nettype none
`include "rp_config.svh"

module rp_analog_io
  import rp_sig_pkg::*;
(
  input  logic                   adc_clk,
  input  logic                   rst_n_i,         // Sync reset, active low
  input  raw_t    [`RP_MNG-1:0]  adc_dat_i,       // Raw ADC codes
  input  sample_t [`RP_MNG-1:0]  asg_smp_i,       // Generator samples
  input  logic                   digital_loop_i,  // Generator feeds ADC path
  output sample_t [`RP_MNG-1:0]  adc_smp_o,       // Converted ADC samples
  output raw_t                   dac_a_o,         // DAC code, channel 0
  output raw_t                   dac_b_o          // DAC code, channel 1
);

// DAC code for sample 0
localparam raw_t DAC_ZERO = {1'b0, {(`RP_SDW-1){1'b1}}};

raw_t [`RP_MNG-1:0] adc_raw_q;
raw_t               dac_a_q;
raw_t               dac_b_q;

// Negative slope offset binary and two's complement, same both ways
function automatic logic [`RP_SDW-1:0] slope_flip(input logic [`RP_SDW-1:0] code);
  return {code[`RP_SDW-1], ~code[`RP_SDW-2:0]};
endfunction

////////////////////////////////////////////////////////////
// ADC side
////////////////////////////////////////////////////////////

always_ff @(posedge adc_clk)
begin
  adc_raw_q <= adc_dat_i;  // Input registers
end

always_comb
begin
  for (int i = 0; i < `RP_MNG; i++)
  begin
    adc_smp_o[i] = digital_loop_i ? asg_smp_i[i] : sample_t'(slope_flip(adc_raw_q[i]));
  end
end

// DAC side, one more register stage
always_ff @(posedge adc_clk)
begin
  if (!rst_n_i)
  begin
    dac_a_q <= DAC_ZERO;
    dac_b_q <= DAC_ZERO;
  end
  else
  begin
    dac_a_q <= slope_flip(asg_smp_i[0]);
    dac_b_q <= slope_flip(asg_smp_i[1]);
  end
end

assign dac_a_o = dac_a_q;
assign dac_b_o = dac_b_q;

endmodule : rp_analog_io

`default_nettype wire

// File: hw/rp_analog_top.sv
// Analog signal path top level
// Bus decoder, generator channels and analog IO

`timescale 1ns/10ps
`default_nettype none
`include "rp_config.svh"

module rp_analog_top
  import rp_bus_pkg::*, rp_sig_pkg::*;
(
  input  logic                  adc_clk,
  input  logic                  rst_n_i,    // Sync reset, active low
  input  sys_req_t              sys_req_i,  // System bus
  output sys_rsp_t              sys_rsp_o,
  input  raw_t [`RP_MNG-1:0]    adc_dat_i,  // Raw ADC codes
  output raw_t                  dac_a_o,
  output raw_t                  dac_b_o,
  output logic [`RP_MNG-1:0]    trig_o      // Generator wrap pulses
);

asg_cfg_t [`RP_MNG-1:0] asg_cfg;       // Decoder to channels
sample_t  [`RP_MNG-1:0] asg_smp;       // Channels to analog IO
sample_t  [`RP_MNG-1:0] adc_smp;       // Converted ADC to housekeeping
logic                   digital_loop;

// Registers and bus response
rp_bus_decoder u_decoder (
  .adc_clk        (adc_clk),
  .rst_n_i        (rst_n_i),
  .sys_req_i      (sys_req_i),
  .sys_rsp_o      (sys_rsp_o),
  .adc_smp_i      (adc_smp),
  .cfg_o          (asg_cfg),
  .digital_loop_o (digital_loop)
);

////////////////////////////////////////////////////////////
// Generator channels
////////////////////////////////////////////////////////////

for (genvar i = 0; i < `RP_MNG; i++)
begin : g_asg
  rp_asg_channel u_asg (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .cfg_i   (asg_cfg[i]),
    .smp_o   (asg_smp[i]),
    .trig_o  (trig_o[i])
  );
end

// Converter interface
rp_analog_io u_analog_io (
  .adc_clk        (adc_clk),
  .rst_n_i        (rst_n_i),
  .adc_dat_i      (adc_dat_i),
  .asg_smp_i      (asg_smp),
  .digital_loop_i (digital_loop),
  .adc_smp_o      (adc_smp),
  .dac_a_o        (dac_a_o),
  .dac_b_o        (dac_b_o)
);

endmodule : rp_analog_top

`default_nettype wire

// File: testbench/tb_clk_gen.sv
// Clock and reset source for the testbench
// 20 ns adc_clk, reset held low for 8 cycles

`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen
(
  output logic clk_o,    // adc_clk
  output logic rst_n_o   // Sync reset, active low
);

localparam real HALF_NS = 10.0;  // 20 ns period

initial
begin
  clk_o   = 1'b0;
  rst_n_o = 1'b0;
  repeat (8) @(posedge clk_o);
  @(negedge clk_o);
  rst_n_o = 1'b1;  // Released away from the sampling edge
end

always #(HALF_NS) clk_o = ~clk_o;

endmodule : tb_clk_gen

`default_nettype wire

// File: testbench/tb_rp_analog.sv
// Testbench for the analog signal path top level
// Bus tasks, LFSR stimulus, assertions, per test report and run limit

`timescale 1ns/10ps
`default_nettype none
`include "rp_config.svh"

module tb_rp_analog
  import rp_bus_pkg::*, rp_sig_pkg::*;
;

localparam int   ADC_N     = 16;                            // Raw codes per ADC channel
localparam int   TRIG_STEP = 4096;                          // 16 cycle wrap period
localparam raw_t SLOPE_MSK = {1'b0, {(`RP_SDW-1){1'b1}}};  // Bits inverted by conversion
// Run limit from the test lengths in cycles
localparam int   TEST_LEN  = 12 + 10 + ADC_N * `RP_MNG * 3 + 2 * (`RP_TDP + 40)
                             + 6 * (65536 / TRIG_STEP) + 40;
localparam int   RUN_LIMIT = 2 * TEST_LEN;

logic               clk;
logic               rst_n;
sys_req_t           sys_req;
sys_rsp_t           sys_rsp;
raw_t [`RP_MNG-1:0] adc_dat;
raw_t               dac_a;
raw_t               dac_b;
logic [`RP_MNG-1:0] trig;

sample_t     tbl [`RP_MNG][`RP_TDP];  // Model of each table
logic [31:0] lfsr_q = 32'd79232;      // Seed
logic [31:0] rdata;
int          err_cnt  = 0;
int          err_mark = 0;
int          pass_cnt = 0;
int          fail_cnt = 0;
int          cyc_cnt  = 0;

tb_clk_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

rp_analog_top dut (
  .adc_clk   (clk),
  .rst_n_i   (rst_n),
  .sys_req_i (sys_req),
  .sys_rsp_o (sys_rsp),
  .adc_dat_i (adc_dat),
  .dac_a_o   (dac_a),
  .dac_b_o   (dac_b),
  .trig_o    (trig)
);

////////////////////////////////////////////////////////////
// Helpers
////////////////////////////////////////////////////////////

// Galois LFSR, one step per bit taken
function automatic logic [31:0] lfsr_take(input int nbits);
  logic [31:0] v;
  v = '0;
  for (int b = 0; b < nbits; b++)
  begin
    v      = {v[30:0], lfsr_q[0]};
    lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hA300_0000) : (lfsr_q >> 1);
  end
  return v;
endfunction

function automatic logic [`RP_SAW-1:0] bus_addr(input logic [3:0] rgn, input logic [15:0] off);
  return {rgn, off};
endfunction

function automatic logic [3:0] ch_rgn(input int ch);
  return 4'(int'(REG_CH0) + ch);
endfunction

// Raw ADC code to sign extended bus word, MSB kept and the rest inverted
function automatic logic [31:0] adc_word(input raw_t r);
  raw_t s;
  s = r ^ SLOPE_MSK;
  return {{(32-`RP_SDW){s[`RP_SDW-1]}}, s};
endfunction

function automatic raw_t dac_code(input sample_t s);
  return raw_t'(s) ^ SLOPE_MSK;
endfunction

task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
  assert (got === exp)
  else
  begin
    $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    err_cnt++;
  end
endtask

// Called on a falling edge, returns on the next one with the response
task automatic bus_write(input logic [`RP_SAW-1:0] addr, input logic [31:0] data);
  sys_req.addr  = addr;
  sys_req.wdata = data;
  sys_req.wen   = 1'b1;
  @(negedge clk);
  sys_req.wen = 1'b0;
  check_eq("sys_rsp_o.ack", 32'(sys_rsp.ack), 32'h1);
  check_eq("sys_rsp_o.err", 32'(sys_rsp.err), 32'h0);
endtask

task automatic bus_read(input logic [`RP_SAW-1:0] addr, input logic exp_err,
                        output logic [31:0] data);
  sys_req.addr = addr;
  sys_req.ren  = 1'b1;
  @(negedge clk);
  sys_req.ren = 1'b0;
  check_eq("sys_rsp_o.ack", 32'(sys_rsp.ack), 32'h1);
  check_eq("sys_rsp_o.err", 32'(sys_rsp.err), 32'(exp_err));
  data = sys_rsp.rdata;
endtask

task automatic load_table(input int ch);
  for (int e = 0; e < `RP_TDP; e++)
  begin
    tbl[ch][e] = sample_t'(lfsr_take(`RP_SDW));
    bus_write(bus_addr(ch_rgn(ch), 16'(32'h8000 + 4 * e)), 32'(tbl[ch][e]));
  end
endtask

task automatic test_end(input string name);
  if (err_cnt == err_mark)
  begin
    pass_cnt++;
    $display("Test %s: passed", name);
  end
  else
  begin
    fail_cnt++;
    $display("Test %s: failed with %0d errors", name, err_cnt - err_mark);
  end
  err_mark = err_cnt;
endtask

// Plays a table from the third edge after enable, then disables
task automatic play_check(input int ch, input int step);
  raw_t got;
  bus_write(bus_addr(ch_rgn(ch), 16'(CR_STEP)), 32'(step));
  bus_write(bus_addr(ch_rgn(ch), 16'(CR_CTRL)), 32'h1);
  repeat (3) @(negedge clk);
  for (int k = 0; k < 24; k++)
  begin
    got = (ch == 0) ? dac_a : dac_b;
    check_eq(ch == 0 ? "dac_a_o" : "dac_b_o", 32'(got),
             32'(dac_code(tbl[ch][8'((k * step) >> 8)])));
    @(negedge clk);
  end
  bus_write(bus_addr(ch_rgn(ch), 16'(CR_CTRL)), 32'h0);
  repeat (3) @(negedge clk);
  check_eq("dac_a_o", 32'(dac_a), 32'h1FFF);
  check_eq("dac_b_o", 32'(dac_b), 32'h1FFF);
endtask

////////////////////////////////////////////////////////////
// Concurrent checks
////////////////////////////////////////////////////////////

a_ack: assert property (@(posedge clk) disable iff (!rst_n)
  (sys_req.wen || sys_req.ren) |=> sys_rsp.ack)
else
begin
  $display("Bus strobe got no ack on the next cycle");
  err_cnt++;
end

a_no_ack: assert property (@(posedge clk) disable iff (!rst_n)
  !(sys_req.wen || sys_req.ren) |=> !sys_rsp.ack && !sys_rsp.err)
else
begin
  $display("Ack or err raised without a bus strobe");
  err_cnt++;
end

a_trig_w: assert property (@(posedge clk) disable iff (!rst_n) trig[1] |=> !trig[1])
else
begin
  $display("Trigger pulse of channel 1 longer than one cycle");
  err_cnt++;
end

// Run limit
always @(posedge clk)
begin
  cyc_cnt <= cyc_cnt + 1;
  if (cyc_cnt >= RUN_LIMIT)
  begin
    $display("Timeout: run did not finish within %0d cycles", RUN_LIMIT);
    $display("RESULT: FAIL");
    $finish;
  end
end

////////////////////////////////////////////////////////////
// Test sequence
////////////////////////////////////////////////////////////

initial
begin
  int last;
  int seen;
  sys_req = '0;
  adc_dat = '0;

  // Reset values, sampled while reset is still held
  repeat (2) @(negedge clk);
  check_eq("sys_rsp_o.ack", 32'(sys_rsp.ack), 32'h0);
  check_eq("sys_rsp_o.err", 32'(sys_rsp.err), 32'h0);
  check_eq("trig_o", 32'(trig), 32'h0);
  check_eq("dac_a_o", 32'(dac_a), 32'h1FFF);
  check_eq("dac_b_o", 32'(dac_b), 32'h1FFF);
  test_end("reset");
  wait (rst_n);
  @(negedge clk);

  // Bus map
  bus_read(bus_addr(REG_HK, 16'h0), 1'b0, rdata);
  check_eq("hk id", rdata, `RP_ID);
  bus_write(bus_addr(REG_HK, 16'h4), 32'h1);
  bus_read(bus_addr(REG_HK, 16'h4), 1'b0, rdata);
  check_eq("hk digital_loop", rdata, 32'h1);
  bus_write(bus_addr(REG_HK, 16'h4), 32'h0);
  bus_read(bus_addr(REG_HK, 16'h4), 1'b0, rdata);
  check_eq("hk digital_loop", rdata, 32'h0);
  bus_read(bus_addr(4'h7, 16'h0), 1'b1, rdata);  // Unmapped region
  test_end("bus");

  // ADC conversion, raw code settles one edge before the read strobe
  for (int n = 0; n < ADC_N; n++)
  begin
    for (int ch = 0; ch < `RP_MNG; ch++)
    begin
      adc_dat[ch] = raw_t'(lfsr_take(`RP_SDW));
      @(negedge clk);
      bus_read(bus_addr(REG_HK, 16'(8 + 4 * ch)), 1'b0, rdata);
      check_eq("hk adc sample", rdata, adc_word(adc_dat[ch]));
    end
  end
  test_end("adc");

  // Playback
  load_table(0);
  load_table(1);
  play_check(0, 256);
  play_check(1, 512);
  test_end("playback");

  // Trigger spacing on channel 1
  bus_write(bus_addr(ch_rgn(1), 16'(CR_STEP)), 32'(TRIG_STEP));
  bus_write(bus_addr(ch_rgn(1), 16'(CR_CTRL)), 32'h1);
  seen = 0;
  last = 0;
  for (int c = 0; c < 5 * (65536 / TRIG_STEP) && seen < 4; c++)
  begin
    @(negedge clk);
    check_eq("trig_o[0]", 32'(trig[0]), 32'h0);
    if (trig[1])
    begin
      if (seen > 0)
        check_eq("trig_o[1] period", 32'(c - last), 32'(65536 / TRIG_STEP));
      last = c;
      seen++;
    end
  end
  assert (seen == 4)
  else
  begin
    $display("Trigger of channel 1 pulsed %0d times instead of 4", seen);
    err_cnt++;
  end
  bus_write(bus_addr(ch_rgn(1), 16'(CR_CTRL)), 32'h0);
  test_end("trigger");

  // Digital loop, a read strobe sampled j edges after enable returns entry j-3
  bus_write(bus_addr(REG_HK, 16'h4), 32'h1);
  bus_write(bus_addr(ch_rgn(0), 16'(CR_STEP)), 32'd256);
  bus_write(bus_addr(ch_rgn(0), 16'(CR_CTRL)), 32'h1);
  repeat (10) @(negedge clk);
  for (int k = 8; k < 12; k++)
  begin
    bus_read(bus_addr(REG_HK, 16'h8), 1'b0, rdata);
    check_eq("hk adc sample 0", rdata, 32'(tbl[0][k]));
  end
  bus_read(bus_addr(REG_HK, 16'hC), 1'b0, rdata);  // Idle channel loops zero
  check_eq("hk adc sample 1", rdata, 32'h0);
  bus_write(bus_addr(ch_rgn(0), 16'(CR_CTRL)), 32'h0);
  bus_write(bus_addr(REG_HK, 16'h4), 32'h0);
  test_end("digital loop");

  $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
           pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
  if (err_cnt == 0 && fail_cnt == 0)
  begin
    $display("RESULT: PASS");
  end
  else
  begin
    $display("RESULT: FAIL");
  end
  $finish;
end

endmodule : tb_rp_analog

`default_nettype wire

// File: flist.f
+incdir+.
hw/rp_bus_pkg.sv
hw/rp_sig_pkg.sv
hw/rp_bus_decoder.sv
hw/rp_asg_channel.sv
hw/rp_analog_io.sv
hw/rp_analog_top.sv
testbench/tb_clk_gen.sv
testbench/tb_rp_analog.sv

// File: Makefile
# Verilator build and run of the analog signal path testbench

VERILATOR ?= verilator
TOP       ?= tb_rp_analog
BUILD_DIR ?= obj_dir
FLIST     ?= flist.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FLIST)) rp_config.svh
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf $(BUILD_DIR)
